//--- design/turfio_bus_pkg.sv
`default_nettype none

package turfio_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    // Byte address across the whole register space
    localparam int WB_ADR_W = 22;
    localparam int WB_DAT_W = 32;
    // Each slave owns 4 kB of byte address
    localparam int WB_SLV_ADR_W = 12;
    // Slave index sits in the address bits above the slave window
    localparam int WB_SLV_IDX_W = WB_ADR_W - WB_SLV_ADR_W;

    //////////////////////////////////////////////////////////////////////
    // Slave map
    //////////////////////////////////////////////////////////////////////

    localparam int WB_NUM_SLV = 3;
    // Identification and board control
    localparam int SLV_ID_CTRL = 0;
    // TURF command decoder
    localparam int SLV_CMD = 1;
    // Sync strobe and cycle counter
    localparam int SLV_TIME = 2;

    // Master to slave request held until ack
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master response with data valid on ack
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- design/turfio_cmd_pkg.sv
`default_nettype none

package turfio_cmd_pkg;

    // TURF command word width
    localparam int CMD_W = 32;
    localparam int CMD_KIND_W = 4;
    // Trigger time carried in the low bits of a command
    localparam int TRIG_TIME_W = 15;
    // Bits between the kind field and the trigger time
    localparam int CMD_RSVD_W = CMD_W - CMD_KIND_W - TRIG_TIME_W;

    // Free-running cycle count
    localparam int COUNT_W = 48;
    // Sync phase counter with a 16-cycle period
    localparam int SYNC_PERIOD_W = 4;

    typedef logic [TRIG_TIME_W-1:0] trig_time_t;

    // Command kinds other than these are dropped
    typedef enum logic [CMD_KIND_W-1:0] {
        CMD_NONE = 4'd0,
        CMD_SYNC = 4'd1,
        CMD_PPS  = 4'd2,
        CMD_TRIG = 4'd3
    } cmd_kind_e;

    // Kind in 31:28 and trigger time in 14:0
    typedef struct packed {
        cmd_kind_e             kind;
        logic [CMD_RSVD_W-1:0] rsvd;
        trig_time_t            trig_time;
    } cmd_word_t;

endpackage

`default_nettype wire

//--- design/turfio_intercon.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_intercon #(
    parameter int NUM_SLV = 3
) (
    input  wire                      wb_clk_i,
    input  wire                      arst_n_i,
    input  turfio_bus_pkg::wb_req_t  host_req_i,
    output turfio_bus_pkg::wb_rsp_t  host_rsp_o,
    output turfio_bus_pkg::wb_req_t  slv_req_o [NUM_SLV],
    input  turfio_bus_pkg::wb_rsp_t  slv_rsp_i [NUM_SLV]
);

    localparam int IDX_W = turfio_bus_pkg::WB_SLV_IDX_W;
    localparam int SLV_ADR_W = turfio_bus_pkg::WB_SLV_ADR_W;

    // Slave index from the top address bits
    logic [IDX_W-1:0] slv_idx;
    logic             unmapped;
    // Own ack for holes in the map
    logic             unm_ack_q;

    assign slv_idx = host_req_i.adr[turfio_bus_pkg::WB_ADR_W-1:SLV_ADR_W];
    assign unmapped = (slv_idx >= IDX_W'(NUM_SLV));

    //////////////////////////////////////////////////////////////////////
    // Request fan-out
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_SLV; i++) begin
            slv_req_o[i] = host_req_i;
            // Only the addressed slave sees stb
            slv_req_o[i].stb = host_req_i.stb && (slv_idx == IDX_W'(i));
            // Slaves decode their own window only
            slv_req_o[i].adr = '0;
            slv_req_o[i].adr[SLV_ADR_W-1:0] = host_req_i.adr[SLV_ADR_W-1:0];
        end
    end

    // One-cycle zero-data ack for an unmapped access
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= host_req_i.cyc && host_req_i.stb && unmapped && !unm_ack_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Default covers the unmapped indices
        host_rsp_o.ack = unm_ack_q;
        host_rsp_o.dat = '0;
        for (int i = 0; i < NUM_SLV; i++) begin
            if (slv_idx == IDX_W'(i)) begin
                host_rsp_o = slv_rsp_i[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tio_id_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tio_id_ctrl #(
    parameter logic [31:0] IDENT = "TFIO",
    parameter logic [31:0] DATEVERSION = 32'h0
) (
    input  wire                     wb_clk_i,
    input  wire                     arst_n_i,
    input  turfio_bus_pkg::wb_req_t wb_req_i,
    output turfio_bus_pkg::wb_rsp_t wb_rsp_o,
    input  wire  [1:0]              crate_conf_i,
    output logic                    enable_crate_o,
    output logic                    enable_3v3_o,
    output logic                    ext_sync_en_o,
    output logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] sync_offset_o
);

    localparam int SLV_ADR_W = turfio_bus_pkg::WB_SLV_ADR_W;

    // Register map, byte offsets
    localparam logic [SLV_ADR_W-1:0] ADR_IDENT = 12'h000;
    localparam logic [SLV_ADR_W-1:0] ADR_DATEVER = 12'h004;
    localparam logic [SLV_ADR_W-1:0] ADR_CTRL = 12'h008;
    localparam logic [SLV_ADR_W-1:0] ADR_CONF = 12'h00C;

    // Control register fields
    typedef struct packed {
        logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] sync_offset;
        logic                                     ext_sync_en;
        logic                                     en_3v3;
        logic                                     en_crate;
    } ctrl_reg_t;

    ctrl_reg_t                             ctrl_q;
    logic                                  ack_q;
    logic                                  access;
    logic [SLV_ADR_W-1:0]                  reg_adr;
    logic [turfio_bus_pkg::WB_DAT_W-1:0]   rdata_d;
    logic [turfio_bus_pkg::WB_DAT_W-1:0]   rdata_q;

    // New access but not the cycle that acks it
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign reg_adr = wb_req_i.adr[SLV_ADR_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_d = '0;
        case (reg_adr)
            ADR_IDENT: rdata_d = IDENT;
            ADR_DATEVER: rdata_d = DATEVERSION;
            ADR_CTRL: begin
                rdata_d[0] = ctrl_q.en_crate;
                rdata_d[1] = ctrl_q.en_3v3;
                rdata_d[2] = ctrl_q.ext_sync_en;
                rdata_d[11:8] = ctrl_q.sync_offset;
            end
            // Crate config straps
            ADR_CONF: rdata_d[1:0] = crate_conf_i;
            default: rdata_d = '0;
        endcase
    end

    // Ack and control state
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            ctrl_q <= '0;
        end else begin
            ack_q <= access;
            // Only the control register is writable
            if (access && wb_req_i.we && reg_adr == ADR_CTRL) begin
                ctrl_q.en_crate <= wb_req_i.dat[0];
                ctrl_q.en_3v3 <= wb_req_i.dat[1];
                ctrl_q.ext_sync_en <= wb_req_i.dat[2];
                ctrl_q.sync_offset <= wb_req_i.dat[11:8];
            end
        end
    end

    // Read data captured with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    assign enable_crate_o = ctrl_q.en_crate;
    assign enable_3v3_o = ctrl_q.en_3v3;
    assign ext_sync_en_o = ctrl_q.ext_sync_en;
    assign sync_offset_o = ctrl_q.sync_offset;

endmodule

`default_nettype wire

//--- design/turf_command_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module turf_command_decoder (
    input  wire                        wb_clk_i,
    input  wire                        arst_n_i,
    input  turfio_bus_pkg::wb_req_t    wb_req_i,
    output turfio_bus_pkg::wb_rsp_t    wb_rsp_o,
    input  turfio_cmd_pkg::cmd_word_t  command_i,
    input  wire                        command_valid_i,
    output turfio_cmd_pkg::trig_time_t trig_time_o,
    output logic                       trig_valid_o,
    output logic                       sync_req_o
);

    localparam int DAT_W = turfio_bus_pkg::WB_DAT_W;
    localparam int SLV_ADR_W = turfio_bus_pkg::WB_SLV_ADR_W;

    // Read-only event counters
    typedef struct packed {
        logic [DAT_W-1:0] trig;
        logic [DAT_W-1:0] pps;
        logic [DAT_W-1:0] sync;
    } evt_count_t;

    evt_count_t                 count_q;
    turfio_cmd_pkg::trig_time_t trig_time_q;
    logic                       trig_valid_q;
    logic                       sync_req_q;
    logic                       is_trig;
    logic                       is_sync;
    logic                       is_pps;
    logic                       ack_q;
    logic                       access;
    logic [DAT_W-1:0]           rdata_q;

    // Decode qualified by the strobe
    assign is_trig = command_valid_i && command_i.kind == turfio_cmd_pkg::CMD_TRIG;
    assign is_sync = command_valid_i && command_i.kind == turfio_cmd_pkg::CMD_SYNC;
    assign is_pps = command_valid_i && command_i.kind == turfio_cmd_pkg::CMD_PPS;

    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    //////////////////////////////////////////////////////////////////////
    // Event registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trig_valid_q <= 1'b0;
            sync_req_q <= 1'b0;
            trig_time_q <= '0;
            count_q <= '0;
            ack_q <= 1'b0;
        end else begin
            // One-cycle pulses in the cycle after the strobe
            trig_valid_q <= is_trig;
            sync_req_q <= is_sync;
            if (is_trig) begin
                trig_time_q <= command_i.trig_time;
                count_q.trig <= count_q.trig + 1'b1;
            end
            if (is_pps) count_q.pps <= count_q.pps + 1'b1;
            if (is_sync) count_q.sync <= count_q.sync + 1'b1;
            ack_q <= access;
        end
    end

    // Read data is zero outside the four words
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= '0;
            case (wb_req_i.adr[SLV_ADR_W-1:0])
                12'h000: rdata_q[turfio_cmd_pkg::TRIG_TIME_W-1:0] <= trig_time_q;
                12'h004: rdata_q <= count_q.trig;
                12'h008: rdata_q <= count_q.pps;
                12'h00C: rdata_q <= count_q.sync;
                default: rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    assign trig_time_o = trig_time_q;
    assign trig_valid_o = trig_valid_q;
    assign sync_req_o = sync_req_q;

endmodule

`default_nettype wire

//--- design/sync_sysclk_count.sv
`timescale 1ns/100ps
`default_nettype none

module sync_sysclk_count (
    input  wire                     wb_clk_i,
    input  wire                     arst_n_i,
    input  turfio_bus_pkg::wb_req_t wb_req_i,
    output turfio_bus_pkg::wb_rsp_t wb_rsp_o,
    input  wire                     sync_req_i,
    input  wire                     ext_sync_en_i,
    input  wire  [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] sync_offset_i,
    output logic                    sync_o
);

    localparam int COUNT_W = turfio_cmd_pkg::COUNT_W;
    localparam int DAT_W = turfio_bus_pkg::WB_DAT_W;

    logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] phase_q;
    logic [COUNT_W-1:0]                       count_q;
    logic                                     ack_q;
    logic                                     access;
    logic [DAT_W-1:0]                         rdata_q;

    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    //////////////////////////////////////////////////////////////////////
    // Phase and cycle count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= '0;
            count_q <= '0;
            ack_q <= 1'b0;
        end else begin
            // TURF sync realigns only when enabled
            if (sync_req_i && ext_sync_en_i) phase_q <= '0;
            else phase_q <= phase_q + 1'b1;
            count_q <= count_q + 1'b1;
            ack_q <= access;
        end
    end

    // Strobe on the programmed phase
    assign sync_o = (phase_q == sync_offset_i);

    // Count halves captured on the edge that raises ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= '0;
            case (wb_req_i.adr[turfio_bus_pkg::WB_SLV_ADR_W-1:0])
                12'h000: rdata_q <= count_q[DAT_W-1:0];
                12'h004: rdata_q[COUNT_W-DAT_W-1:0] <= count_q[COUNT_W-1:DAT_W];
                default: rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

//--- design/turfio_top.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_top #(
    parameter logic [31:0] IDENT = "TFIO",
    parameter logic [3:0]  VER_MAJOR = 4'd0,
    parameter logic [3:0]  VER_MINOR = 4'd0,
    parameter logic [7:0]  VER_REV = 8'd23,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0
) (
    input  wire                        wb_clk_i,
    input  wire                        arst_n_i,
    input  turfio_bus_pkg::wb_req_t    wb_req_i,
    output turfio_bus_pkg::wb_rsp_t    wb_rsp_o,
    input  turfio_cmd_pkg::cmd_word_t  command_i,
    input  wire                        command_valid_i,
    input  wire  [1:0]                 crate_conf_i,
    output logic                       enable_crate_o,
    output logic                       enable_3v3_o,
    output logic                       sync_o,
    output turfio_cmd_pkg::trig_time_t trig_time_o,
    output logic                       trig_valid_o
);

    // Date in the top half and version below
    localparam logic [15:0] FIRMWARE_VERSION = {VER_MAJOR, VER_MINOR, VER_REV};
    localparam logic [31:0] DATEVERSION = {FIRMWARE_DATE, FIRMWARE_VERSION};

    localparam int NUM_SLV = turfio_bus_pkg::WB_NUM_SLV;

    turfio_bus_pkg::wb_req_t slv_req [NUM_SLV];
    turfio_bus_pkg::wb_rsp_t slv_rsp [NUM_SLV];

    // Control levels into the sync block
    logic                                     ext_sync_en;
    logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] sync_offset;
    // Sync request from the command path
    logic                                     sync_req;

    //////////////////////////////////////////////////////////////////////
    // Bus fabric
    //////////////////////////////////////////////////////////////////////

    turfio_intercon #(
        .NUM_SLV(NUM_SLV)
    ) u_intercon (
        .wb_clk_i(wb_clk_i),
        .arst_n_i(arst_n_i),
        .host_req_i(wb_req_i),
        .host_rsp_o(wb_rsp_o),
        .slv_req_o(slv_req),
        .slv_rsp_i(slv_rsp)
    );

    // Slave 0
    tio_id_ctrl #(
        .IDENT(IDENT),
        .DATEVERSION(DATEVERSION)
    ) u_id_ctrl (
        .wb_clk_i(wb_clk_i),
        .arst_n_i(arst_n_i),
        .wb_req_i(slv_req[turfio_bus_pkg::SLV_ID_CTRL]),
        .wb_rsp_o(slv_rsp[turfio_bus_pkg::SLV_ID_CTRL]),
        .crate_conf_i(crate_conf_i),
        .enable_crate_o(enable_crate_o),
        .enable_3v3_o(enable_3v3_o),
        .ext_sync_en_o(ext_sync_en),
        .sync_offset_o(sync_offset)
    );

    // Slave 1
    turf_command_decoder u_decoder (
        .wb_clk_i(wb_clk_i),
        .arst_n_i(arst_n_i),
        .wb_req_i(slv_req[turfio_bus_pkg::SLV_CMD]),
        .wb_rsp_o(slv_rsp[turfio_bus_pkg::SLV_CMD]),
        .command_i(command_i),
        .command_valid_i(command_valid_i),
        .trig_time_o(trig_time_o),
        .trig_valid_o(trig_valid_o),
        .sync_req_o(sync_req)
    );

    // Slave 2
    sync_sysclk_count u_synccount (
        .wb_clk_i(wb_clk_i),
        .arst_n_i(arst_n_i),
        .wb_req_i(slv_req[turfio_bus_pkg::SLV_TIME]),
        .wb_rsp_o(slv_rsp[turfio_bus_pkg::SLV_TIME]),
        .sync_req_i(sync_req),
        .ext_sync_en_i(ext_sync_en),
        .sync_offset_i(sync_offset),
        .sync_o(sync_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_turfio_model.svh
`ifndef TB_TURFIO_MODEL_SVH
`define TB_TURFIO_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model state
//////////////////////////////////////////////////////////////////////

// Control register fields as the host programs them
typedef struct packed {
    logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] sync_offset;
    logic                                     ext_sync_en;
    logic                                     en_3v3;
    logic                                     en_crate;
} model_ctrl_t;

model_ctrl_t                              m_ctrl;
// Sync phase and cycle count of the current cycle
logic [turfio_cmd_pkg::SYNC_PERIOD_W-1:0] m_phase;
logic [turfio_cmd_pkg::COUNT_W-1:0]       m_count;
// High in the cycle where the decoder passes a sync request on
logic                                     m_sync_req;
turfio_cmd_pkg::trig_time_t               m_last_trig;
logic [31:0]                              m_trig_cnt;
logic [31:0]                              m_pps_cnt;
logic [31:0]                              m_sync_cnt;
int                                       checks_done;

task automatic model_reset();
    m_ctrl = '0;
    m_phase = '0;
    m_count = '0;
    m_sync_req = 1'b0;
    m_last_trig = '0;
    m_trig_cnt = 0;
    m_pps_cnt = 0;
    m_sync_cnt = 0;
    checks_done = 0;
endtask

// Only the control word of slave 0 keeps written data
task automatic model_bus_write(input logic [21:0] adr, input logic [31:0] dat);
    if (adr == 22'h000008) begin
        m_ctrl.en_crate = dat[0];
        m_ctrl.en_3v3 = dat[1];
        m_ctrl.ext_sync_en = dat[2];
        m_ctrl.sync_offset = dat[11:8];
    end
endtask

task automatic model_command(input turfio_cmd_pkg::cmd_word_t cmd);
    case (cmd.kind)
        turfio_cmd_pkg::CMD_TRIG: begin
            m_last_trig = cmd.trig_time;
            m_trig_cnt = m_trig_cnt + 1;
        end
        turfio_cmd_pkg::CMD_PPS: m_pps_cnt = m_pps_cnt + 1;
        turfio_cmd_pkg::CMD_SYNC: m_sync_cnt = m_sync_cnt + 1;
        default: ;
    endcase
    m_sync_req = (cmd.kind == turfio_cmd_pkg::CMD_SYNC);
endtask

// Control word as slave 0 reads it back
function automatic logic [31:0] ctrl_readback();
    return {20'b0, m_ctrl.sync_offset, 5'b0, m_ctrl.ext_sync_en, m_ctrl.en_3v3, m_ctrl.en_crate};
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1);
endtask

task automatic compare_word(input string name, input logic [turfio_bus_pkg::WB_DAT_W-1:0] exp,
                            input logic [turfio_bus_pkg::WB_DAT_W-1:0] act);
    checks_done++;
    if (act !== exp) begin
        $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    checks_done++;
    if (act !== exp) begin
        $display("FAIL %s expected %b actual %b", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic compare_trig(input string name, input turfio_cmd_pkg::trig_time_t exp,
                            input turfio_cmd_pkg::trig_time_t act);
    checks_done++;
    if (act !== exp) begin
        $display("FAIL %s expected 0x%04h actual 0x%04h", name, exp, act);
        stop_with_failure();
    end
endtask

// Count must fall inside the window lo..hi
task automatic compare_count(input string name, input logic [turfio_cmd_pkg::COUNT_W-1:0] lo,
                             input logic [turfio_cmd_pkg::COUNT_W-1:0] hi,
                             input logic [turfio_cmd_pkg::COUNT_W-1:0] act);
    checks_done++;
    if (act < lo || act > hi) begin
        $display("FAIL %s expected %0d..%0d actual %0d", name, lo, hi, act);
        stop_with_failure();
    end
endtask

`endif

//--- testbench/tb_turfio_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_turfio_top;

    localparam logic [31:0] IDENT = "TFIO";
    localparam logic [3:0]  VER_MAJOR = 4'd1;
    localparam logic [3:0]  VER_MINOR = 4'd4;
    localparam logic [7:0]  VER_REV = 8'd23;
    localparam logic [15:0] FW_DATE = 16'h5A3C;
    // Date 5A3C over version 1.4 and revision 0x17
    localparam logic [31:0] DATEVERSION_EXP = 32'h5A3C_1417;
    localparam int SEED = 81969;
    localparam int N_CTRL = 24;
    localparam int N_CMD = 64;
    localparam int N_CNT = 4;
    localparam int N_UNM = 6;
    // Bus accesses of all test phases
    localparam int N_BUS_OPS = 2 + 3 * N_CTRL + 6 + N_CMD / 8 + 4 + 2 * N_CNT + N_UNM;
    // 20 clock periods of 4 ns for every access and command
    localparam int TIMEOUT_NS = (N_BUS_OPS + N_CMD) * 20 * 4;
    // Slave windows with the index in address bits 21:12
    localparam logic [21:0] ID_BASE = 22'h000000;
    localparam logic [21:0] CMD_BASE = 22'h001000;
    localparam logic [21:0] TIME_BASE = 22'h002000;

    logic                       clk = 1'b0;
    logic                       arst_n;
    turfio_bus_pkg::wb_req_t    wb_req;
    turfio_bus_pkg::wb_rsp_t    wb_rsp;
    turfio_cmd_pkg::cmd_word_t  command;
    logic                       command_valid;
    logic [1:0]                 crate_conf;
    logic                       enable_crate;
    logic                       enable_3v3;
    logic                       sync;
    turfio_cmd_pkg::trig_time_t trig_time;
    logic                       trig_valid;
    // Model cycle count at request start and at ack of the last access
    logic [47:0]                start_count;
    logic [47:0]                ack_count;

    `include "tb_turfio_model.svh"

    turfio_top #(
        .IDENT(IDENT),
        .VER_MAJOR(VER_MAJOR),
        .VER_MINOR(VER_MINOR),
        .VER_REV(VER_REV),
        .FIRMWARE_DATE(FW_DATE)
    ) u_dut (
        .wb_clk_i(clk),
        .arst_n_i(arst_n),
        .wb_req_i(wb_req),
        .wb_rsp_o(wb_rsp),
        .command_i(command),
        .command_valid_i(command_valid),
        .crate_conf_i(crate_conf),
        .enable_crate_o(enable_crate),
        .enable_3v3_o(enable_3v3),
        .sync_o(sync),
        .trig_time_o(trig_time),
        .trig_valid_o(trig_valid)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Per-cycle sync strobe check and model clock
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!arst_n) begin
            m_phase = '0;
            m_count = '0;
        end else begin
            // Values of the cycle that ends at this edge
            compare_bit("sync strobe", m_phase == m_ctrl.sync_offset, sync);
            if (m_sync_req && m_ctrl.ext_sync_en) begin
                m_phase = '0;
            end else begin
                m_phase = m_phase + 4'd1;
            end
            m_count = m_count + 48'd1;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the DUT stopped answering the bus", TIMEOUT_NS);
        stop_with_failure();
    end

    // One access with the request held until ack and stb low for a cycle after
    task automatic bus_transfer(input logic we, input logic [21:0] adr, input logic [31:0] wdat,
                                output logic [31:0] rdat);
        turfio_bus_pkg::wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat = wdat;
        @(posedge clk);
        wb_req <= req;
        @(negedge clk);
        start_count = m_count;
        while (!wb_rsp.ack) @(negedge clk);
        ack_count = m_count;
        rdat = wb_rsp.dat;
        // Write lands on the ack edge
        if (we) model_bus_write(adr, wdat);
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic bus_write(input logic [21:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        bus_transfer(1'b1, adr, dat, unused_rd);
    endtask

    task automatic bus_read(input logic [21:0] adr, output logic [31:0] dat);
        bus_transfer(1'b0, adr, '0, dat);
    endtask

    // One-cycle command strobe with events one cycle later
    task automatic send_command(input turfio_cmd_pkg::cmd_word_t cmd);
        logic is_trig;
        is_trig = (cmd.kind == turfio_cmd_pkg::CMD_TRIG);
        @(posedge clk);
        command <= cmd;
        command_valid <= 1'b1;
        @(posedge clk);
        command_valid <= 1'b0;
        @(negedge clk);
        compare_bit("trigger valid", is_trig, trig_valid);
        if (is_trig) compare_trig("trigger time", cmd.trig_time, trig_time);
        model_command(cmd);
        @(negedge clk);
        compare_bit("trigger pulse end", 1'b0, trig_valid);
        m_sync_req = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        logic [31:0]               rd;
        logic [31:0]               wd;
        logic [1:0]                conf;
        logic [47:0]               cnt;
        logic [47:0]               prev_cnt;
        logic [47:0]               lo_start;
        logic [9:0]                idx;
        turfio_cmd_pkg::cmd_word_t cmd;
        void'($urandom(SEED));
        arst_n = 1'b0;
        wb_req = '0;
        command = '0;
        command_valid = 1'b0;
        crate_conf = 2'b00;
        model_reset();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // Identification words
        bus_read(ID_BASE + 22'h000, rd);
        compare_word("ident", IDENT, rd);
        bus_read(ID_BASE + 22'h004, rd);
        compare_word("date and version", DATEVERSION_EXP, rd);

        // Control register and crate straps
        for (int i = 0; i < N_CTRL; i++) begin
            wd = $urandom();
            bus_write(ID_BASE + 22'h008, wd);
            @(negedge clk);
            compare_bit("crate enable", wd[0], enable_crate);
            compare_bit("3V3 enable", wd[1], enable_3v3);
            bus_read(ID_BASE + 22'h008, rd);
            compare_word("control readback", wd & 32'h0000_0F07, rd);
            conf = 2'($urandom_range(0, 3));
            @(posedge clk);
            crate_conf <= conf;
            bus_read(ID_BASE + 22'h00C, rd);
            compare_word("crate config", {30'b0, conf}, rd);
        end

        // Writes to read-only words
        bus_write(ID_BASE + 22'h000, $urandom());
        bus_write(ID_BASE + 22'h004, $urandom());
        bus_write(ID_BASE + 22'h00C, $urandom());
        bus_read(ID_BASE + 22'h000, rd);
        compare_word("ident after write", IDENT, rd);
        bus_read(ID_BASE + 22'h004, rd);
        compare_word("version after write", DATEVERSION_EXP, rd);
        bus_read(ID_BASE + 22'h008, rd);
        compare_word("control unchanged", ctrl_readback(), rd);

        // Random commands with sync enable and offset reprogrammed now and then
        for (int i = 0; i < N_CMD; i++) begin
            if (i % 8 == 0) bus_write(ID_BASE + 22'h008, $urandom());
            cmd = turfio_cmd_pkg::cmd_word_t'({4'($urandom_range(0, 5)), 28'($urandom())});
            send_command(cmd);
            repeat ($urandom_range(0, 3)) @(posedge clk);
        end
        bus_read(CMD_BASE + 22'h000, rd);
        compare_word("last trigger time", {17'b0, m_last_trig}, rd);
        bus_read(CMD_BASE + 22'h004, rd);
        compare_word("trigger count", m_trig_cnt, rd);
        bus_read(CMD_BASE + 22'h008, rd);
        compare_word("PPS count", m_pps_cnt, rd);
        bus_read(CMD_BASE + 22'h00C, rd);
        compare_word("sync request count", m_sync_cnt, rd);

        // Cycle counter read as low word then high word
        prev_cnt = '0;
        for (int i = 0; i < N_CNT; i++) begin
            bus_read(TIME_BASE + 22'h000, rd);
            lo_start = start_count;
            cnt[31:0] = rd;
            bus_read(TIME_BASE + 22'h004, rd);
            cnt[47:32] = rd[15:0];
            compare_count("cycle count", lo_start, ack_count, cnt);
            compare_count("cycle count increase", prev_cnt + 48'd1, '1, cnt);
            prev_cnt = cnt;
            repeat ($urandom_range(0, 7)) @(posedge clk);
        end

        // Holes in the slave map
        for (int i = 0; i < N_UNM; i++) begin
            idx = 10'($urandom_range(3, 1023));
            bus_read({idx, 10'($urandom()), 2'b00}, rd);
            compare_word("unmapped read", '0, rd);
        end

        if (checks_done > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("No checks were run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+testbench
design/turfio_bus_pkg.sv
design/turfio_cmd_pkg.sv
design/turfio_intercon.sv
design/tio_id_ctrl.sv
design/turf_command_decoder.sv
design/sync_sysclk_count.sv
design/turfio_top.sv
testbench/tb_turfio_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_turfio_top -o tb_turfio_top
./obj_dir/tb_turfio_top | tee sim.log
if grep -qx "Verification passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
